// File: hw/syscfg_cmd_if.sv
interface syscfg_cmd_if import syscfg_pkg::*; ();

    logic  req;
    logic  ack;
    logic  we;
    tgt_t  tgt;
    reg_t  rg;
    data_t wdata;

    // fields stay put while req is high.
    modport prod (
        output req,
        output we,
        output tgt,
        output rg,
        output wdata,
        input  ack
    );

    modport cons (
        input  req,
        input  we,
        input  tgt,
        input  rg,
        input  wdata,
        output ack
    );

endinterface

// File: hw/syscfg_cmd_queue.sv
module syscfg_cmd_queue import syscfg_pkg::*; (
    input logic clk,
    input logic rst,

    syscfg_cmd_if.cons in_cmd,
    syscfg_cmd_if.prod out_cmd
);

    logic  mem_we    [CMD_DEPTH];
    tgt_t  mem_tgt   [CMD_DEPTH];
    reg_t  mem_rg    [CMD_DEPTH];
    data_t mem_wdata [CMD_DEPTH];

    q_ptr_t   wr_ptr;
    q_ptr_t   rd_ptr;
    q_cnt_t   count;
    q_state_t state;

    logic full;
    logic push;
    logic pop;

    assign full = (count == q_cnt_t'(CMD_DEPTH));
    assign push = in_cmd.req && !in_cmd.ack && !full; // new request only.
    assign pop  = (state == Q_REQ) && out_cmd.ack;

    // ------------------------------------------------------------
    // input side
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            in_cmd.ack <= 1'b0;
            wr_ptr     <= '0;
        end else if (in_cmd.ack) begin
            if (!in_cmd.req) in_cmd.ack <= 1'b0;
        end else if (push) begin
            in_cmd.ack <= 1'b1;
            wr_ptr     <= wr_ptr + q_ptr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_we[wr_ptr]    <= in_cmd.we;
            mem_tgt[wr_ptr]   <= in_cmd.tgt;
            mem_rg[wr_ptr]    <= in_cmd.rg;
            mem_wdata[wr_ptr] <= in_cmd.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + q_cnt_t'(1);
                2'b01:   count <= count - q_cnt_t'(1);
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------
    // output side
    // ------------------------------------------------------------

    assign out_cmd.we    = mem_we[rd_ptr];    // head entry.
    assign out_cmd.tgt   = mem_tgt[rd_ptr];
    assign out_cmd.rg    = mem_rg[rd_ptr];
    assign out_cmd.wdata = mem_wdata[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= Q_IDLE;
            out_cmd.req <= 1'b0;
            rd_ptr      <= '0;
        end else begin
            case (state)
                Q_IDLE: begin
                    if (count != '0) begin
                        out_cmd.req <= 1'b1;
                        state       <= Q_REQ;
                    end
                end
                Q_REQ: begin
                    if (pop) begin
                        out_cmd.req <= 1'b0;
                        rd_ptr      <= rd_ptr + q_ptr_t'(1);
                        state       <= Q_WAIT_LOW;
                    end
                end
                Q_WAIT_LOW: begin
                    if (!out_cmd.ack) state <= Q_IDLE;
                end
                default: state <= Q_IDLE;
            endcase
        end
    end

endmodule

// File: hw/syscfg_pkg.sv
package syscfg_pkg;

    // ------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------

    localparam int NO_TGTS   = 4;
    localparam int CMD_DEPTH = 4;
    localparam int IRQ_WIDTH = 8;

    localparam int Q_PTR_W = $clog2(CMD_DEPTH);
    localparam int Q_CNT_W = $clog2(CMD_DEPTH + 1);

    typedef logic [3:0]           addr_t;     // {tgt, reg} word address.
    typedef logic [1:0]           tgt_t;
    typedef logic [1:0]           reg_t;
    typedef logic [31:0]          data_t;
    typedef logic [31:0]          boot_addr_t;
    typedef logic [IRQ_WIDTH-1:0] irq_vec_t;
    typedef logic [NO_TGTS-1:0]   tgt_vec_t;  // one bit per target.
    typedef logic [Q_PTR_W-1:0]   q_ptr_t;
    typedef logic [Q_CNT_W-1:0]   q_cnt_t;

    // only target 0 comes up on its own.
    localparam tgt_vec_t BOOTSTRAP_MASK = 4'b0001;

    // ------------------------------------------------------------
    // register map
    // ------------------------------------------------------------

    localparam reg_t REG_CTRL = 2'd0;
    localparam reg_t REG_BOOT = 2'd1;
    localparam reg_t REG_MASK = 2'd2;
    localparam reg_t REG_STAT = 2'd3; // read only.

    localparam int CTRL_RST_BIT   = 0;
    localparam int CTRL_PAUSE_BIT = 1;
    localparam int CTRL_PACK_BIT  = 2; // live pause_ack on read.

    typedef enum logic [1:0] {DEC_IDLE, DEC_PUSH, DEC_WAIT_RSP, DEC_DONE} dec_state_t;
    typedef enum logic [1:0] {Q_IDLE, Q_REQ, Q_WAIT_LOW} q_state_t;
    typedef enum logic {BANK_IDLE, BANK_ACK} bank_state_t;

endpackage

// File: hw/syscfg_reg_decoder.sv
module syscfg_reg_decoder import syscfg_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  bus_req,
    input  logic  bus_we,
    input  addr_t bus_addr,
    input  data_t bus_wdata,
    output logic  bus_ack,
    output data_t bus_rdata,

    syscfg_cmd_if.prod cmd,

    input  logic  rsp_valid,
    input  data_t rsp_data
);

    dec_state_t state;

    // ------------------------------------------------------------
    // bus handshake and command push
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= DEC_IDLE;
            bus_ack <= 1'b0;
            cmd.req <= 1'b0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    // previous command must be fully closed.
                    if (bus_req && !cmd.ack) begin
                        cmd.req <= 1'b1;
                        state   <= DEC_PUSH;
                    end
                end
                DEC_PUSH: begin
                    if (cmd.ack) begin
                        cmd.req <= 1'b0;
                        if (cmd.we) begin
                            bus_ack <= 1'b1; // posted write.
                            state   <= DEC_DONE;
                        end else begin
                            state <= DEC_WAIT_RSP;
                        end
                    end
                end
                DEC_WAIT_RSP: begin
                    if (rsp_valid) begin
                        bus_ack <= 1'b1;
                        state   <= DEC_DONE;
                    end
                end
                DEC_DONE: begin
                    if (!bus_req) begin
                        bus_ack <= 1'b0;
                        state   <= DEC_IDLE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // payload
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (state == DEC_IDLE && bus_req && !cmd.ack) begin
            cmd.we             <= bus_we;
            {cmd.tgt, cmd.rg}  <= bus_addr;  // upper bits pick the target.
            cmd.wdata          <= bus_wdata;
        end
    end

    // held until the next read completes.
    always_ff @(posedge clk) begin
        if (state == DEC_WAIT_RSP && rsp_valid) begin
            bus_rdata <= rsp_data;
        end
    end

endmodule

// File: hw/syscfg_tgt_bank.sv
module syscfg_tgt_bank import syscfg_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    syscfg_cmd_if.cons cmd,

    output logic       rsp_valid,
    output data_t      rsp_data,

    input  irq_vec_t   irq_in,

    output tgt_vec_t   tgt_rst,
    output tgt_vec_t   pause_req,
    input  tgt_vec_t   pause_ack,
    output boot_addr_t boot_addr [NO_TGTS],
    output tgt_vec_t   tgt_irq
);

    bank_state_t state;
    irq_vec_t    mask [NO_TGTS];
    data_t       rd_val;
    logic        take;

    // command applied in the cycle it is acknowledged.
    assign take = (state == BANK_IDLE) && cmd.req;

    // ------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= BANK_IDLE;
            cmd.ack   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            case (state)
                BANK_IDLE: begin
                    if (take) begin
                        cmd.ack   <= 1'b1;
                        rsp_valid <= !cmd.we; // reads only.
                        state     <= BANK_ACK;
                    end
                end
                BANK_ACK: begin
                    rsp_valid <= 1'b0;
                    if (!cmd.req) begin
                        cmd.ack <= 1'b0;
                        state   <= BANK_IDLE;
                    end
                end
                default: state <= BANK_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // target registers
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            tgt_rst   <= ~BOOTSTRAP_MASK;
            pause_req <= '0;
            for (int i = 0; i < NO_TGTS; i++) begin
                boot_addr[i] <= '0;
                mask[i]      <= '0;
            end
        end else if (take && cmd.we) begin
            case (cmd.rg)
                REG_CTRL: begin
                    tgt_rst[cmd.tgt]   <= cmd.wdata[CTRL_RST_BIT];
                    pause_req[cmd.tgt] <= cmd.wdata[CTRL_PAUSE_BIT];
                end
                REG_BOOT: boot_addr[cmd.tgt] <= cmd.wdata;
                REG_MASK: mask[cmd.tgt]      <= cmd.wdata[IRQ_WIDTH-1:0];
                default:  ;                  // stat ignores writes.
            endcase
        end
    end

    // ------------------------------------------------------------
    // read path
    // ------------------------------------------------------------

    always_comb begin
        rd_val = '0;
        case (cmd.rg)
            REG_CTRL: begin
                rd_val[CTRL_RST_BIT]   = tgt_rst[cmd.tgt];
                rd_val[CTRL_PAUSE_BIT] = pause_req[cmd.tgt];
                rd_val[CTRL_PACK_BIT]  = pause_ack[cmd.tgt]; // sampled live.
            end
            REG_BOOT: rd_val = boot_addr[cmd.tgt];
            REG_MASK: rd_val[IRQ_WIDTH-1:0] = mask[cmd.tgt];
            REG_STAT: rd_val[IRQ_WIDTH-1:0] = irq_in & mask[cmd.tgt];
        endcase
    end

    always_ff @(posedge clk) begin
        if (take && !cmd.we) begin
            rsp_data <= rd_val;
        end
    end

    // ------------------------------------------------------------
    // interrupts
    // ------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < NO_TGTS; i++) begin
            tgt_irq[i] = |(irq_in & mask[i]);
        end
    end

endmodule

// File: hw/syscfg_top.sv
module syscfg_top import syscfg_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // host register bus.
    input  logic       bus_req,
    input  logic       bus_we,
    input  addr_t      bus_addr,
    input  data_t      bus_wdata,
    output logic       bus_ack,
    output data_t      bus_rdata,

    input  irq_vec_t   irq_in,

    // targets.
    output tgt_vec_t   tgt_rst,
    output tgt_vec_t   pause_req,
    input  tgt_vec_t   pause_ack,
    output boot_addr_t boot_addr [NO_TGTS],
    output tgt_vec_t   tgt_irq
);

    syscfg_cmd_if dec_cmd ();
    syscfg_cmd_if bank_cmd ();

    logic  rsp_valid;
    data_t rsp_data;

    syscfg_reg_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .cmd       (dec_cmd.prod),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    syscfg_cmd_queue u_queue (
        .clk     (clk),
        .rst     (rst),
        .in_cmd  (dec_cmd.cons),
        .out_cmd (bank_cmd.prod)
    );

    syscfg_tgt_bank u_bank (
        .clk       (clk),
        .rst       (rst),
        .cmd       (bank_cmd.cons),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .irq_in    (irq_in),
        .tgt_rst   (tgt_rst),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .boot_addr (boot_addr),
        .tgt_irq   (tgt_irq)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the syscfg testbench with Verilator.
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module syscfg_tb \
    -f vlog.f \
    -o syscfg_sim

# keep running after the first assertion so the testbench can report.
./obj_dir/syscfg_sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "^No errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: verification/syscfg_clk_gen.sv
module syscfg_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: verification/syscfg_props.sv
module syscfg_props import syscfg_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       bus_req,
    input logic       bus_we,
    input addr_t      bus_addr,
    input data_t      bus_wdata,
    input logic       bus_ack,
    input data_t      bus_rdata,
    input irq_vec_t   irq_in,
    input tgt_vec_t   tgt_rst,
    input tgt_vec_t   pause_req,
    input tgt_vec_t   pause_ack,
    input boot_addr_t boot_addr [NO_TGTS],
    input tgt_vec_t   tgt_irq
);

    logic       failed = 1'b0;

    tgt_vec_t   sh_rst;
    tgt_vec_t   sh_pause;
    boot_addr_t sh_boot [NO_TGTS];
    irq_vec_t   sh_mask [NO_TGTS];

    tgt_t       acc_tgt;
    reg_t       acc_rg;
    logic       wr_done;
    data_t      exp_rdata;
    logic       outs_ok;
    logic       boot_zero;

    assign {acc_tgt, acc_rg} = bus_addr;
    assign wr_done = bus_req && bus_we && bus_ack; // posted write seen at the port.

    // ------------------------------------------------------------
    // shadow registers
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            sh_rst   <= ~BOOTSTRAP_MASK;
            sh_pause <= '0;
            for (int i = 0; i < NO_TGTS; i++) begin
                sh_boot[i] <= '0;
                sh_mask[i] <= '0;
            end
        end else if (wr_done) begin
            case (acc_rg)
                REG_CTRL: begin
                    sh_rst[acc_tgt]   <= bus_wdata[CTRL_RST_BIT];
                    sh_pause[acc_tgt] <= bus_wdata[CTRL_PAUSE_BIT];
                end
                REG_BOOT: sh_boot[acc_tgt] <= bus_wdata;
                REG_MASK: sh_mask[acc_tgt] <= bus_wdata[IRQ_WIDTH-1:0];
                default:  ;                // stat is read only.
            endcase
        end
    end

    always_comb begin
        exp_rdata = '0;
        case (acc_rg)
            REG_CTRL: begin
                exp_rdata[CTRL_RST_BIT]   = sh_rst[acc_tgt];
                exp_rdata[CTRL_PAUSE_BIT] = sh_pause[acc_tgt];
                exp_rdata[CTRL_PACK_BIT]  = pause_ack[acc_tgt];
            end
            REG_BOOT: exp_rdata = sh_boot[acc_tgt];
            REG_MASK: exp_rdata[IRQ_WIDTH-1:0] = sh_mask[acc_tgt];
            default:  exp_rdata[IRQ_WIDTH-1:0] = irq_in & sh_mask[acc_tgt];
        endcase
    end

    always_comb begin
        outs_ok   = (tgt_rst == sh_rst) && (pause_req == sh_pause);
        boot_zero = 1'b1;
        for (int i = 0; i < NO_TGTS; i++) begin
            outs_ok   = outs_ok && (boot_addr[i] == sh_boot[i]);
            outs_ok   = outs_ok && (tgt_irq[i] == |(irq_in & sh_mask[i]));
            boot_zero = boot_zero && (boot_addr[i] == '0);
        end
    end

    // ------------------------------------------------------------
    // properties
    // ------------------------------------------------------------

    a_reset_values: assert property (@(posedge clk)
        $fell(rst) |-> (!bus_ack && pause_req == '0 && tgt_rst == ~BOOTSTRAP_MASK && boot_zero))
        else begin
            $error("MISMATCH %0t: outputs differ from their reset values", $time);
            failed = 1'b1;
        end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_ack) |-> bus_req)
        else begin
            $error("bus_ack rose at %0t while bus_req was low", $time);
            failed = 1'b1;
        end

    a_ack_holds: assert property (@(posedge clk) disable iff (rst)
        bus_ack && bus_req |=> bus_ack)
        else begin
            $error("bus_ack fell at %0t while bus_req was still high", $time);
            failed = 1'b1;
        end

    a_ack_drops: assert property (@(posedge clk) disable iff (rst)
        bus_ack && !bus_req |=> !bus_ack)
        else begin
            $error("bus_ack stayed high at %0t after bus_req fell", $time);
            failed = 1'b1;
        end

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_ack) && !bus_we |-> bus_rdata == exp_rdata)
        else begin
            $error("MISMATCH %0t: read of %h returned %h, expected %h",
                   $time, bus_addr, bus_rdata, exp_rdata);
            failed = 1'b1;
        end

    // every earlier write must be visible once a read completes.
    a_ordering: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_ack) && !bus_we |-> outs_ok)
        else begin
            $error("MISMATCH %0t: target outputs lag the completed writes", $time);
            failed = 1'b1;
        end

endmodule

bind syscfg_top syscfg_props u_props (
    .clk       (clk),
    .rst       (rst),
    .bus_req   (bus_req),
    .bus_we    (bus_we),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_ack   (bus_ack),
    .bus_rdata (bus_rdata),
    .irq_in    (irq_in),
    .tgt_rst   (tgt_rst),
    .pause_req (pause_req),
    .pause_ack (pause_ack),
    .boot_addr (boot_addr),
    .tgt_irq   (tgt_irq)
);

// File: verification/syscfg_tb.sv
module syscfg_tb import syscfg_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int RAND_ACCESSES   = 48;
    localparam int N_ACCESSES      = 20 + 4 + 22 + RAND_ACCESSES;
    localparam int WATCHDOG_CYCLES = N_ACCESSES * 40 + 500;

    logic       clk;
    logic       rst;
    logic       bus_req;
    logic       bus_we;
    addr_t      bus_addr;
    data_t      bus_wdata;
    logic       bus_ack;
    data_t      bus_rdata;
    irq_vec_t   irq_in;
    tgt_vec_t   tgt_rst;
    tgt_vec_t   pause_req;
    tgt_vec_t   pause_ack = '0;
    boot_addr_t boot_addr [NO_TGTS];
    tgt_vec_t   tgt_irq;

    int seed = 32'h73fe_330a;
    int ack_wait [NO_TGTS];

    syscfg_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    syscfg_top dut (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .irq_in    (irq_in),
        .tgt_rst   (tgt_rst),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .boot_addr (boot_addr),
        .tgt_irq   (tgt_irq)
    );

    // ------------------------------------------------------------
    // target pause model
    // ------------------------------------------------------------

    always @(posedge clk) begin
        int delay;
        for (int i = 0; i < NO_TGTS; i++) begin
            if (rst) begin
                pause_ack[i] <= 1'b0;
                ack_wait[i]  <= 0;
            end else if (pause_ack[i] == pause_req[i]) begin
                ack_wait[i] <= 0;
            end else if (ack_wait[i] == 0) begin
                delay = 1 + ($unsigned($random(seed)) % 4); // 1 to 4 cycles.
                if (delay == 1) begin
                    pause_ack[i] <= pause_req[i];
                end else begin
                    ack_wait[i] <= delay - 1;
                end
            end else if (ack_wait[i] == 1) begin
                pause_ack[i] <= pause_req[i];
                ack_wait[i]  <= 0;
            end else begin
                ack_wait[i] <= ack_wait[i] - 1;
            end
        end
    end

    // ------------------------------------------------------------
    // bus tasks
    // ------------------------------------------------------------

    task automatic bus_access(input logic we, input addr_t addr, input data_t data);
        @(posedge clk);
        bus_req   <= 1'b1;
        bus_we    <= we;
        bus_addr  <= addr;
        bus_wdata <= data;
        @(posedge clk);
        while (bus_ack !== 1'b1) @(posedge clk);
        bus_req <= 1'b0;
        @(posedge clk);
        while (bus_ack !== 1'b0) @(posedge clk);
    endtask

    task automatic write_reg(input tgt_t t, input reg_t r, input data_t data);
        bus_access(1'b1, {t, r}, data);
    endtask

    task automatic read_reg(input tgt_t t, input reg_t r);
        bus_access(1'b0, {t, r}, '0);
    endtask

    // posted write, so pause_req may still be on its way.
    task automatic wait_pause(input tgt_t t, input logic want);
        while (pause_req[t] !== want || pause_ack[t] !== want) @(posedge clk);
    endtask

    task automatic new_irq_pattern();
        @(posedge clk);
        irq_in <= irq_vec_t'($random(seed));
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    initial begin
        addr_t addr;
        data_t data;
        logic  we;

        bus_req   <= 1'b0;
        bus_we    <= 1'b0;
        bus_addr  <= '0;
        bus_wdata <= '0;
        irq_in    <= '0;
        while (rst !== 1'b0) @(posedge clk);
        repeat (2) @(posedge clk);

        for (int t = 0; t < NO_TGTS; t++) begin
            write_reg(tgt_t'(t), REG_BOOT, data_t'($random(seed)));
            read_reg(tgt_t'(t), REG_BOOT);
            write_reg(tgt_t'(t), REG_MASK, data_t'($random(seed)));
            new_irq_pattern();
            read_reg(tgt_t'(t), REG_MASK);
            read_reg(tgt_t'(t), REG_STAT);
        end

        write_reg(2'd2, REG_CTRL, 32'h0000_0002); // out of reset, paused.
        wait_pause(2'd2, 1'b1);
        read_reg(2'd2, REG_CTRL);
        write_reg(2'd2, REG_CTRL, 32'h0000_0000);
        wait_pause(2'd2, 1'b0);
        read_reg(2'd2, REG_CTRL);

        // six posted writes, more than the queue holds.
        write_reg(2'd0, REG_BOOT, data_t'($random(seed)));
        write_reg(2'd1, REG_BOOT, data_t'($random(seed)));
        write_reg(2'd2, REG_BOOT, data_t'($random(seed)));
        write_reg(2'd3, REG_BOOT, data_t'($random(seed)));
        write_reg(2'd1, REG_MASK, 32'h0000_00ff);
        write_reg(2'd3, REG_CTRL, 32'h0000_0000);
        for (int t = 0; t < NO_TGTS; t++) begin
            for (int r = 0; r < 4; r++) begin
                read_reg(tgt_t'(t), reg_t'(r));
            end
        end

        for (int n = 0; n < RAND_ACCESSES; n++) begin
            addr = addr_t'($random(seed));
            data = data_t'($random(seed));
            we   = 1'($random(seed));
            if (n % 8 == 0) new_irq_pattern();
            bus_access(we, addr, data);
            if (we && addr[1:0] == REG_CTRL) wait_pause(addr[3:2], data[CTRL_PAUSE_BIT]);
        end

        repeat (4) @(posedge clk);
        if (dut.u_props.failed) begin
            $display("Errors found");
            $fatal(1, "property checks failed during the run");
        end else begin
            $display("No errors");
            $finish;
        end
    end

    initial begin
        wait (dut.u_props.failed === 1'b1);
        $display("Errors found");
        $fatal(1, "a property check failed, stopping");
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Errors found");
        $fatal(1, "simulation timed out before all bus accesses finished");
    end

endmodule

// File: vlog.f
hw/syscfg_pkg.sv
hw/syscfg_cmd_if.sv
hw/syscfg_reg_decoder.sv
hw/syscfg_cmd_queue.sv
hw/syscfg_tgt_bank.sv
hw/syscfg_top.sv
verification/syscfg_clk_gen.sv
verification/syscfg_props.sv
verification/syscfg_tb.sv
